// ==== hdl/cpuPkg.sv ====
package cpuPkg;

   // Instruction word layout
   localparam int instrWidth  = 32;        // Bits per instruction word
   localparam int opcodeWidth = 8;         // Opcode field size
   localparam int immWidth    = 12;        // Immediate field size

   // Field start positions inside the instruction word
   localparam int opcodeLsb = 24;          // Opcode in bits 31..24
   localparam int rdLsb     = 20;          // Destination in bits 23..20
   localparam int rnLsb     = 16;          // First source in bits 19..16
   localparam int rmLsb     = 12;          // Second source in bits 15..12
   localparam int immLsb    = 0;           // Immediate in bits 11..0

   // Instruction codes understood by the core
   typedef enum logic [opcodeWidth-1:0] {
      OP_ADD  = 8'h08,                     // Rd = rn + rm
      OP_SUB  = 8'h04,                     // Rd = rn - rm
      OP_ADDI = 8'h28,                     // Rd = rn + imm
      OP_SUBI = 8'h24,                     // Rd = rn - imm
      OP_MOVI = 8'h3A,                     // Rd = imm
      OP_MOVR = 8'h1A,                     // Rd = rm
      OP_LDRP = 8'h51,                     // Rd = mem[rn + imm]
      OP_LDRN = 8'h59,                     // Rd = mem[rn - imm]
      OP_STRN = 8'h50                      // Mem[rn - imm] = rd
   } opcodeT;

   // ALU class handed from the decoder to the ALU control
   typedef enum logic [1:0] {
      ALUOP_ADDR = 2'b00,                  // Load/store address math
      ALUOP_FUNC = 2'b10                   // Opcode picks the function
   } aluOpT;

   // Operation actually carried out by the ALU
   typedef enum logic [1:0] {
      ALU_ADD   = 2'b00,                   // A plus B
      ALU_SUB   = 2'b01,                   // A minus B
      ALU_PASSB = 2'b10                    // B straight through
   } aluFuncT;

   // Datapath steering levels produced by the decoder
   typedef struct packed {
      logic  reg2Loc;                      // Second read port takes rd when set
      logic  aluSrc;                       // Immediate as operand B
      logic  memToReg;                     // Write back loaded data
      logic  regWrite;                     // Register file write enable
      logic  memRead;                      // Data memory read level
      logic  memWrite;                     // Data memory write strobe
      aluOpT aluOp;                        // ALU class
   } controlWordT;

   // Word for no-ops and unknown codes
   localparam controlWordT ctrlNop = '{
      reg2Loc:  1'b0,
      aluSrc:   1'b0,
      memToReg: 1'b0,
      regWrite: 1'b0,
      memRead:  1'b0,
      memWrite: 1'b0,
      aluOp:    ALUOP_ADDR
   };

endpackage

// ==== hdl/controlUnit.sv ====
module controlUnit
(
   input  cpuPkg::opcodeT      opcode,      // Opcode field of the current instruction
   output cpuPkg::controlWordT ctrl         // Steering levels for the datapath
);

   import cpuPkg::*;

   always_comb
   begin
      ctrl = ctrlNop;                       // Nothing written unless decoded below
      case (opcode)
         OP_ADD,
         OP_SUB:                            // Register-register arithmetic
         begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = ALUOP_FUNC;
         end
         OP_ADDI,
         OP_SUBI:                           // Arithmetic with immediate
         begin
            ctrl.aluSrc   = 1'b1;           // Sign-extended imm as operand B
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = ALUOP_FUNC;
         end
         OP_MOVI:
         begin
            ctrl.aluSrc   = 1'b1;           // ALU passes the immediate
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = ALUOP_FUNC;
         end
         OP_MOVR:
         begin
            ctrl.aluSrc   = 1'b0;           // ALU passes rm from port 2
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = ALUOP_FUNC;
         end
         OP_LDRP,
         OP_LDRN:                           // Loads with either offset sign
         begin
            ctrl.reg2Loc  = 1'b1;
            ctrl.aluSrc   = 1'b1;           // Offset as operand B
            ctrl.memToReg = 1'b1;           // Memory word into rd
            ctrl.regWrite = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.aluOp    = ALUOP_ADDR;
         end
         OP_STRN:
         begin
            ctrl.reg2Loc  = 1'b1;           // Rd out on port 2 as store data
            ctrl.aluSrc   = 1'b1;
            ctrl.memWrite = 1'b1;
            ctrl.aluOp    = ALUOP_ADDR;
         end
         default:
         begin
            ctrl = ctrlNop;                 // Unknown code runs as a no-op
         end
      endcase
   end

endmodule

// ==== hdl/aluControl.sv ====
module aluControl
(
   input  cpuPkg::aluOpT   aluOp,           // Class from the decoder
   input  cpuPkg::opcodeT  opcode,          // Opcode for the function choice
   output cpuPkg::aluFuncT aluFunc          // Function applied by the ALU
);

   import cpuPkg::*;

   always_comb
   begin
      aluFunc = ALU_ADD;                    // Safe choice for any leftover case
      case (aluOp)
         ALUOP_ADDR:                        // Memory address from rn and offset
         begin
            case (opcode)
               OP_LDRP: aluFunc = ALU_ADD;  // Positive offset
               OP_LDRN,
               OP_STRN: aluFunc = ALU_SUB;  // Negative offset
               default: aluFunc = ALU_ADD;
            endcase
         end
         ALUOP_FUNC:
         begin
            case (opcode)
               OP_ADD,
               OP_ADDI: aluFunc = ALU_ADD;
               OP_SUB,
               OP_SUBI: aluFunc = ALU_SUB;
               OP_MOVI,
               OP_MOVR: aluFunc = ALU_PASSB;  // Moves copy operand B
               default: aluFunc = ALU_ADD;
            endcase
         end
         default:
         begin
            aluFunc = ALU_ADD;
         end
      endcase
   end

endmodule

// ==== hdl/alu.sv ====
module alu
#(
   parameter int dataWidth = 32             // Operand and result width
)
(
   input  logic [dataWidth-1:0] a,          // Operand A from read port 1
   input  logic [dataWidth-1:0] b,          // Operand B, register or immediate
   input  cpuPkg::aluFuncT      aluFunc,    // Selected function
   output logic [dataWidth-1:0] result      // Wraps on overflow
);

   import cpuPkg::*;

   always_comb
   begin
      case (aluFunc)
         ALU_ADD:
         begin
            result = a + b;                 // Two's-complement sum
         end
         ALU_SUB:
         begin
            result = a - b;                 // Two's-complement difference
         end
         ALU_PASSB:
         begin
            result = b;                     // Used by the moves
         end
         default:
         begin
            result = a + b;
         end
      endcase
   end

endmodule

// ==== hdl/regFile.sv ====
module regFile
#(
   parameter int dataWidth    = 32,         // Register width
   parameter int regAddrWidth = 4           // 2**regAddrWidth registers
)
(
   input  logic                    clk,
   input  logic                    reset,        // Clears every register
   input  logic [regAddrWidth-1:0] readAddr1,    // Port 1 address, rn
   input  logic [regAddrWidth-1:0] readAddr2,    // Port 2 address, rm or rd
   input  logic [regAddrWidth-1:0] writeAddr,    // Destination rd
   input  logic [dataWidth-1:0]    writeData,    // Write-back value
   input  logic                    writeEnable,  // Write at the next edge
   output logic [dataWidth-1:0]    readData1,
   output logic [dataWidth-1:0]    readData2
);

   localparam int regCount = 2 ** regAddrWidth;

   logic [dataWidth-1:0] regs [regCount];   // Register array

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < regCount; i++)
         begin
            regs[i] <= '0;                  // All registers back to zero
         end
      end
      else if (writeEnable && (writeAddr != '0))
      begin
         regs[writeAddr] <= writeData;      // Register 0 stays untouched
      end
   end

   // Reads see the value from before this cycle's write
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];  // R0 reads zero
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== hdl/dataPath.sv ====
module dataPath
#(
   parameter int dataWidth    = 32,         // Register and memory word width
   parameter int regAddrWidth = 4           // Register address width
)
(
   input  logic                           clk,
   input  logic                           reset,
   input  cpuPkg::controlWordT            ctrl,          // Levels from the decoder
   input  logic [cpuPkg::instrWidth-1:0]  imemData,      // Fetched instruction
   input  logic [dataWidth-1:0]           dmemReadData,  // Loaded word
   output cpuPkg::opcodeT                 opcode,        // Back to the decoder
   output logic [dataWidth-1:0]           imemAddr,      // Word address, the PC
   output logic [dataWidth-1:0]           dmemAddr,      // ALU result
   output logic [dataWidth-1:0]           dmemWriteData, // Rd for stores
   output logic                           dmemWrite,
   output logic                           dmemRead
);

   import cpuPkg::*;

   logic [dataWidth-1:0]    pc;              // Program counter
   logic [regAddrWidth-1:0] rd;              // Destination field
   logic [regAddrWidth-1:0] rn;              // First source field
   logic [regAddrWidth-1:0] rm;              // Second source field
   logic [immWidth-1:0]     imm;             // Raw immediate
   logic [dataWidth-1:0]    immExt;          // Sign-extended immediate
   logic [regAddrWidth-1:0] readAddr2;       // Rm or rd
   logic [dataWidth-1:0]    readData1;
   logic [dataWidth-1:0]    readData2;
   logic [dataWidth-1:0]    operandB;
   logic [dataWidth-1:0]    aluResult;
   logic [dataWidth-1:0]    writeBackData;
   aluFuncT                 aluFunc;

   // One instruction per clock, no branches
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc <= '0;
      end
      else
      begin
         pc <= pc + 1'b1;                     // Next word every cycle
      end
   end

   assign imemAddr = pc;

   // Field split
   assign opcode = opcodeT'(imemData[opcodeLsb +: opcodeWidth]);
   assign rd     = imemData[rdLsb +: regAddrWidth];
   assign rn     = imemData[rnLsb +: regAddrWidth];
   assign rm     = imemData[rmLsb +: regAddrWidth];
   assign imm    = imemData[immLsb +: immWidth];

   assign immExt    = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};  // Same rule for all
   assign readAddr2 = ctrl.reg2Loc ? rd : rm;                 // Stores and loads read rd
   assign operandB  = ctrl.aluSrc ? immExt : readData2;
   assign writeBackData = ctrl.memToReg ? dmemReadData : aluResult;

   regFile #(
      .dataWidth    (dataWidth),
      .regAddrWidth (regAddrWidth)
   ) regFile0 (
      .clk          (clk),
      .reset        (reset),
      .readAddr1    (rn),
      .readAddr2    (readAddr2),
      .writeAddr    (rd),
      .writeData    (writeBackData),
      .writeEnable  (ctrl.regWrite),           // Blocked in reset inside regFile
      .readData1    (readData1),
      .readData2    (readData2)
   );

   aluControl aluControl0 (
      .aluOp   (ctrl.aluOp),
      .opcode  (opcode),
      .aluFunc (aluFunc)
   );

   alu #(
      .dataWidth (dataWidth)
   ) alu0 (
      .a       (readData1),
      .b       (operandB),
      .aluFunc (aluFunc),
      .result  (aluResult)
   );

   // Memory side
   assign dmemAddr      = aluResult;
   assign dmemWriteData = readData2;
   assign dmemWrite     = ctrl.memWrite & ~reset;  // No store while in reset
   assign dmemRead      = ctrl.memRead & ~reset;

endmodule

// ==== hdl/cpuTop.sv ====
module cpuTop
#(
   parameter int dataWidth    = 32,         // 16 also supported
   parameter int regAddrWidth = 4           // 16 registers
)
(
   input  logic                           clk,
   input  logic                           reset,
   output logic [dataWidth-1:0]           imemAddr,      // Instruction word address
   input  logic [cpuPkg::instrWidth-1:0]  imemData,      // Combinational ROM read
   output logic [dataWidth-1:0]           dmemAddr,      // Load/store address
   output logic [dataWidth-1:0]           dmemWriteData, // Store data
   output logic                           dmemWrite,     // One write per high cycle
   output logic                           dmemRead,      // Load in progress
   input  logic [dataWidth-1:0]           dmemReadData   // Combinational RAM read
);

   import cpuPkg::*;

   controlWordT ctrl;                       // Decoder to datapath
   opcodeT      opcode;                     // Datapath to decoder

   controlUnit controlUnit0 (
      .opcode (opcode),
      .ctrl   (ctrl)
   );

   dataPath #(
      .dataWidth    (dataWidth),
      .regAddrWidth (regAddrWidth)
   ) dataPath0 (
      .clk           (clk),
      .reset         (reset),
      .ctrl          (ctrl),
      .imemData      (imemData),
      .dmemReadData  (dmemReadData),
      .opcode        (opcode),
      .imemAddr      (imemAddr),
      .dmemAddr      (dmemAddr),
      .dmemWriteData (dmemWriteData),
      .dmemWrite     (dmemWrite),
      .dmemRead      (dmemRead)
   );

endmodule

// ==== verification/clockGen.sv ====
module clockGen
#(
   parameter int period      = 20,          // Clock period in time units
   parameter int resetCycles = 3            // Rising edges with reset high
)
(
   output logic clk,
   output logic reset                       // Synchronous, active high
);

   initial
   begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;     // Free-running clock
   end

   initial
   begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;                        // Released on a rising edge
   end

endmodule

// ==== verification/cpuTb.sv ====
module cpuTb;

   import cpuPkg::*;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;
   localparam int numTests     = 6;
   localparam int maxProgram   = 60;                   // ROM has 64 words
   localparam int cycleLimit   = 3 * maxProgram + 20;  // 200 cycles incl. reset and margin

   logic                  clk;
   logic                  reset;
   logic [dataWidth-1:0]  imemAddr;
   logic [instrWidth-1:0] imemData;
   logic [dataWidth-1:0]  dmemAddr;
   logic [dataWidth-1:0]  dmemWriteData;
   logic                  dmemWrite;
   logic                  dmemRead;
   logic [dataWidth-1:0]  dmemReadData;

   logic [instrWidth-1:0] rom [64];         // Instruction ROM
   logic [dataWidth-1:0]  ram [256];        // Data RAM
   logic [dataWidth-1:0]  expAddr [64];     // Expected dmemAddr per PC
   logic [dataWidth-1:0]  expData [64];     // Expected store data per PC
   logic                  expWrite [64];
   logic                  expRead [64];
   int                    testOf [64];      // Test owning each instruction
   int                    testEnd [numTests];
   int                    testErrors [numTests];
   int                    totalErrors = 0;
   int                    progLen = 0;
   logic [31:0]           expPc;            // Completed instructions since reset
   logic [5:0]            curIdx;
   logic                  inProgram;
   string testNames [numTests] = '{"resetFetch", "arith", "moves", "loads",
                                   "storeAddr", "unknown"};

   clockGen #(.period(20), .resetCycles(3)) clockGen0 (.clk(clk), .reset(reset));

   cpuTop #(
      .dataWidth    (dataWidth),
      .regAddrWidth (regAddrWidth)
   ) dut0 (
      .clk           (clk),
      .reset         (reset),
      .imemAddr      (imemAddr),
      .imemData      (imemData),
      .dmemAddr      (dmemAddr),
      .dmemWriteData (dmemWriteData),
      .dmemWrite     (dmemWrite),
      .dmemRead      (dmemRead),
      .dmemReadData  (dmemReadData)
   );

   assign imemData     = rom[imemAddr[5:0]];    // Combinational ROM read
   assign dmemReadData = ram[dmemAddr[7:0]];    // Combinational RAM read

   always @(posedge clk)
   begin
      if (dmemWrite)
      begin
         ram[dmemAddr[7:0]] <= dmemWriteData;   // One word per strobe
      end
   end

   // PC rule: zero after reset, plus one per edge
   always @(posedge clk)
   begin
      if (reset)
      begin
         expPc <= '0;
      end
      else
      begin
         expPc <= expPc + 1;
      end
   end

   assign curIdx    = expPc[5:0];
   assign inProgram = !reset && (expPc < progLen);

   task automatic reportMismatch(input string signalName, input logic [31:0] idx,
                                 input logic [31:0] expected, input logic [31:0] actual);
      string name;
      name = (idx < progLen) ? testNames[testOf[idx[5:0]]] : "afterProgram";
      $display("mismatch %s: %s at pc %0d expected 0x%08h actual 0x%08h",
               name, signalName, idx, expected, actual);
      if (idx < progLen)
      begin
         testErrors[testOf[idx[5:0]]]++;
      end
      totalErrors++;
   endtask

   resetNoStore: assert property (@(posedge clk) reset |-> !dmemWrite)
      else begin
         $display("error resetFetch: dmemWrite went high while reset was high");
         testErrors[0]++;
         totalErrors++;
      end

   fetchCheck: assert property (@(posedge clk) disable iff (reset) imemAddr == expPc)
      else reportMismatch("imemAddr", $sampled(expPc), $sampled(expPc), $sampled(imemAddr));

   writeStrobeCheck: assert property (@(posedge clk) inProgram |-> dmemWrite == expWrite[curIdx])
      else reportMismatch("dmemWrite", $sampled(expPc), expWrite[$sampled(curIdx)],
                          $sampled(dmemWrite));

   readStrobeCheck: assert property (@(posedge clk) inProgram |-> dmemRead == expRead[curIdx])
      else reportMismatch("dmemRead", $sampled(expPc), expRead[$sampled(curIdx)],
                          $sampled(dmemRead));

   storeAddrCheck: assert property (@(posedge clk)
                                    inProgram && expWrite[curIdx] |-> dmemAddr == expAddr[curIdx])
      else reportMismatch("store dmemAddr", $sampled(expPc), expAddr[$sampled(curIdx)],
                          $sampled(dmemAddr));

   storeDataCheck: assert property (@(posedge clk)
                                    inProgram && expWrite[curIdx] |->
                                    dmemWriteData == expData[curIdx])
      else reportMismatch("dmemWriteData", $sampled(expPc), expData[$sampled(curIdx)],
                          $sampled(dmemWriteData));

   loadAddrCheck: assert property (@(posedge clk)
                                   inProgram && expRead[curIdx] |-> dmemAddr == expAddr[curIdx])
      else reportMismatch("load dmemAddr", $sampled(expPc), expAddr[$sampled(curIdx)],
                          $sampled(dmemAddr));

   function automatic logic [11:0] randImm();
      return 12'($urandom);
   endfunction

   task automatic emit(input logic [7:0] op, input int rd, input int rn, input int rm,
                       input logic [11:0] imm, input int testId);
      rom[progLen]    = {op, 4'(rd), 4'(rn), 4'(rm), imm};
      testOf[progLen] = testId;
      testEnd[testId] = progLen;            // Last instruction seen so far
      progLen++;
   endtask

   // Store with zero offset from the base in r14
   task automatic storeViaBase(input int rd, input int testId);
      emit(OP_STRN, rd, 14, 0, 12'd0, testId);
   endtask

   task automatic buildProgram();
      for (int i = 0; i < 64; i++)
      begin
         rom[i] = {8'hFF, 18'd0, 6'(i)};    // Undefined opcode tagged with its address
      end
      emit(OP_STRN, 0, 0, 0, 12'd0, 0);     // Store already decoded while reset is high
      emit(OP_MOVI, 1, 0, 0, randImm(), 0);
      emit(OP_MOVI, 2, 0, 0, randImm(), 0);
      emit(OP_MOVI, 3, 0, 0, randImm(), 0);
      emit(OP_MOVI, 14, 0, 0, 12'd16, 0);   // Store base
      emit(OP_ADD, 5, 1, 2, 12'd0, 1);
      storeViaBase(5, 1);
      emit(OP_SUB, 5, 1, 3, 12'd0, 1);
      storeViaBase(5, 1);
      emit(OP_ADDI, 5, 2, 0, randImm(), 1);
      storeViaBase(5, 1);
      emit(OP_SUBI, 5, 3, 0, randImm(), 1);
      storeViaBase(5, 1);
      emit(OP_MOVI, 6, 0, 0, randImm(), 2);
      storeViaBase(6, 2);
      emit(OP_MOVR, 7, 0, 6, 12'd0, 2);
      storeViaBase(7, 2);
      emit(OP_MOVI, 0, 0, 0, randImm(), 2);  // R0 must stay zero
      storeViaBase(0, 2);
      emit(OP_MOVR, 0, 0, 1, 12'd0, 2);
      storeViaBase(0, 2);
      emit(OP_LDRP, 8, 14, 0, 12'($urandom_range(0, 200)), 3);
      storeViaBase(8, 3);
      emit(OP_LDRN, 9, 14, 0, randImm(), 3);
      storeViaBase(9, 3);
      emit(OP_STRN, 1, 14, 0, 12'd5, 3);    // Word at base minus 5
      emit(OP_LDRP, 10, 14, 0, 12'hFFB, 3); // Same word read back
      storeViaBase(10, 3);
      for (int i = 0; i < 4; i++)
      begin
         emit(OP_STRN, $urandom_range(0, 15), $urandom_range(1, 15), 0, randImm(), 4);
      end
      emit(8'hFF, 1, 2, 3, randImm(), 5);
      emit(8'h77, 5, 1, 2, randImm(), 5);
      storeViaBase(1, 5);                   // Both must be unchanged
      storeViaBase(5, 5);
   endtask

   // ISA reference model, run before the first edge so ram holds its initial fill
   task automatic runModel();
      logic [31:0] regs [16];
      logic [31:0] mem [256];
      logic [31:0] w;
      logic [31:0] immExt;
      logic [31:0] addr;
      logic [31:0] value;
      logic [3:0]  rd;
      logic [3:0]  rn;
      logic [3:0]  rm;
      logic        writesReg;
      for (int i = 0; i < 16; i++)
      begin
         regs[i] = '0;
      end
      for (int i = 0; i < 256; i++)
      begin
         mem[i] = ram[i];
      end
      for (int pc = 0; pc < 64; pc++)
      begin
         w            = rom[pc];
         rd           = w[23:20];
         rn           = w[19:16];
         rm           = w[15:12];
         immExt       = {{20{w[11]}}, w[11:0]};
         addr         = regs[rn] - immExt;    // Offset rule of LDRN and STRN
         value        = '0;
         writesReg    = 1'b1;
         expWrite[pc] = 1'b0;
         expRead[pc]  = 1'b0;
         expAddr[pc]  = '0;
         expData[pc]  = '0;
         case (w[31:24])
            OP_ADD:  value = regs[rn] + regs[rm];
            OP_SUB:  value = regs[rn] - regs[rm];
            OP_ADDI: value = regs[rn] + immExt;
            OP_SUBI: value = regs[rn] - immExt;
            OP_MOVI: value = immExt;
            OP_MOVR: value = regs[rm];
            OP_LDRP,
            OP_LDRN:
            begin
               if (w[31:24] == OP_LDRP)
               begin
                  addr = regs[rn] + immExt;
               end
               value       = mem[addr[7:0]];
               expRead[pc] = 1'b1;
               expAddr[pc] = addr;
            end
            OP_STRN:
            begin
               mem[addr[7:0]] = regs[rd];
               expWrite[pc]   = 1'b1;
               expAddr[pc]    = addr;
               expData[pc]    = regs[rd];
               writesReg      = 1'b0;
            end
            default: writesReg = 1'b0;        // Unknown code changes nothing
         endcase
         if (writesReg && (rd != 4'd0))
         begin
            regs[rd] = value;
         end
      end
   endtask

   initial
   begin : mainFlow
      int cycles;
      int nextTest;
      int passed;
      void'($urandom(33));
      for (int i = 0; i < 256; i++)
      begin
         ram[i] = $urandom;
      end
      for (int t = 0; t < numTests; t++)
      begin
         testErrors[t] = 0;
      end
      buildProgram();
      runModel();
      cycles   = 0;
      nextTest = 0;
      passed   = 0;
      while ((nextTest < numTests) && (cycles < cycleLimit))
      begin
         @(negedge clk);                      // Checks of the last edge are done
         cycles++;
         while ((nextTest < numTests) && !reset && (expPc > testEnd[nextTest]))
         begin
            $display("test %-10s %s (%0d errors)", testNames[nextTest],
                     (testErrors[nextTest] == 0) ? "passed" : "failed",
                     testErrors[nextTest]);
            if (testErrors[nextTest] == 0)
            begin
               passed++;
            end
            nextTest++;
         end
      end
      if (nextTest < numTests)
      begin
         $display("timeout: program did not finish within %0d cycles", cycleLimit);
         $display("Simulation finished: FAIL");
      end
      else
      begin
         $display("tests: %0d passed, %0d failed, checks failed: %0d",
                  passed, numTests - passed, totalErrors);
         if (totalErrors == 0)
         begin
            $display("Simulation finished: PASS");
         end
         else
         begin
            $display("Simulation finished: FAIL");
         end
      end
      $finish;
   end

endmodule

// ==== project.f ====
hdl/cpuPkg.sv
hdl/controlUnit.sv
hdl/aluControl.sv
hdl/alu.sv
hdl/regFile.sv
hdl/dataPath.sv
hdl/cpuTop.sv
verification/clockGen.sv
verification/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - hdl/cpuPkg.sv
  - hdl/controlUnit.sv
  - hdl/aluControl.sv
  - hdl/alu.sv
  - hdl/regFile.sv
  - hdl/dataPath.sv
  - hdl/cpuTop.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/cpuTb.sv
